//--- design/mac_rx_pkg.sv
// shared types and constants for the byte-level RGMII receive MAC
// rgmii_rx_t holds one already-captured DDR pair, so no io timing is modelled here
// crc constants assume the reflected CRC-32 used by 802.3, lsb first on the wire
package mac_rx_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    typedef logic [7:0]  byte_t;        // one octet
    typedef logic [15:0] frame_cnt_t;   // byte index within a frame
    typedef logic [31:0] crc_t;         // crc shift register

    // one mac_rx_clk cycle as captured from the phy
    typedef struct packed {
        byte_t data;                    // rxd, both nibbles
        logic  ctl_rise;                // rx_dv
        logic  ctl_fall;                // rx_dv ^ rx_er
    } rgmii_rx_t;

    // payload beat, preamble already stripped
    typedef struct packed {
        byte_t data;
        logic  valid;                   // one-cycle strobe, no handshake
        logic  first;                   // first byte after sfd
        logic  last;                    // final byte, fcs included
        logic  err;                     // rx_er seen on this byte
    } rx_beat_t;

    // user-side stream
    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  sof;
        logic  eof;
    } mac_rx_stream_t;

    // ------------------------------------------------------------------------
    // in-band status, sent by the phy in the interframe gap
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        SPEED_10M  = 2'b00,             // rxc at 2.5 MHz
        SPEED_100M = 2'b01,             // rxc at 25 MHz
        SPEED_1G   = 2'b10              // rxc at 125 MHz
    } link_speed_e;

    typedef struct packed {
        logic        link_up;
        link_speed_e speed;
        logic        full_duplex;
    } link_status_t;

    // ------------------------------------------------------------------------
    // framing and fcs
    // ------------------------------------------------------------------------
    localparam int   PREAMBLE_LEN  = 8;              // 7 x 0x55 + sfd
    localparam crc_t CRC_INIT      = '1;
    localparam crc_t CRC_POLY_REFL = 32'hEDB88320;   // 0x04C11DB7 bit-reversed
    localparam crc_t CRC_RESIDUE   = 32'hC704DD7B;   // good frame, msb-first form

endpackage

//--- design/mac_rx_top.sv
// receive half of an RGMII MAC at byte level, one clock domain (mac_rx_clk)
// no back-pressure: the user side must take every beat as it comes
// OUT_PIPE_DEPTH must stay in 1..16
`timescale 1ns/1ps

module mac_rx_top #(
    parameter int OUT_PIPE_DEPTH = 5    // output delay line length
) (
    input  logic                        mac_rx_clk,
    input  logic                        rst_n_i,

    // phy side, one captured ddr pair per cycle
    input  mac_rx_pkg::rgmii_rx_t       rgmii_rx_i,

    // user side
    output mac_rx_pkg::mac_rx_stream_t  mac_rx_o,
    output logic                        fr_good_o,      // fcs ok, with eof
    output logic                        fr_err_o,       // rx_er in frame, with eof
    output mac_rx_pkg::link_status_t    link_status_o   // in-band phy status
);
    import mac_rx_pkg::*;

    // ------------------------------------------------------------------------
    // internal wiring
    // ------------------------------------------------------------------------
    rx_beat_t beat;         // stripped payload, to crc and output stage
    logic     fcs_ok;       // level, valid from 1 edge after last beat

    // preamble/sfd strip, er decode, gap status
    rx_frame_ctrl u_frame_ctrl (
        .mac_rx_clk    (mac_rx_clk),
        .rst_n_i       (rst_n_i),
        .rgmii_rx_i    (rgmii_rx_i),
        .beat_o        (beat),
        .link_status_o (link_status_o)
    );

    // running crc over payload + fcs
    rx_crc32_check u_crc32_check (
        .mac_rx_clk (mac_rx_clk),
        .rst_n_i    (rst_n_i),
        .beat_i     (beat),
        .fcs_ok_o   (fcs_ok)
    );

    // delay line, verdicts meet eof here
    rx_stream_out #(
        .OUT_PIPE_DEPTH (OUT_PIPE_DEPTH)
    ) u_stream_out (
        .mac_rx_clk (mac_rx_clk),
        .rst_n_i    (rst_n_i),
        .beat_i     (beat),
        .fcs_ok_i   (fcs_ok),
        .mac_rx_o   (mac_rx_o),
        .fr_good_o  (fr_good_o),
        .fr_err_o   (fr_err_o)
    );

endmodule

//--- design/rx_crc32_check.sv
// CRC-32 residue check, byte-wise, over every payload beat including the fcs
// fcs_ok_o updates 1 edge after the last beat and holds until the next first beat
`timescale 1ns/1ps

module rx_crc32_check (
    input  logic                  mac_rx_clk,
    input  logic                  rst_n_i,
    input  mac_rx_pkg::rx_beat_t  beat_i,
    output logic                  fcs_ok_o
);
    import mac_rx_pkg::*;

    crc_t crc_q;        // running register, reflected form
    crc_t crc_seed;
    crc_t crc_nxt;

    // ------------------------------------------------------------------------
    // one byte through the reflected lfsr, lsb first
    // ------------------------------------------------------------------------
    function automatic crc_t crc32_byte(input crc_t crc_in, input byte_t d);
        crc_t c;
        c = crc_in ^ {24'h0, d};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY_REFL) : (c >> 1);
        end
        return c;
    endfunction

    // residue constant is given msb first
    function automatic crc_t bit_rev(input crc_t c);
        crc_t r;
        for (int b = 0; b < 32; b++) begin
            r[b] = c[31-b];
        end
        return r;
    endfunction

    assign crc_seed = beat_i.first ? CRC_INIT : crc_q;    // restart per frame
    assign crc_nxt  = crc32_byte(crc_seed, beat_i.data);

    always_ff @(posedge mac_rx_clk) begin
        if (beat_i.valid) begin
            crc_q <= crc_nxt;
        end
    end

    // verdict, a single-byte frame is both first and last so last wins
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fcs_ok_o <= 1'b0;
        end else if (beat_i.valid && beat_i.last) begin
            fcs_ok_o <= (bit_rev(crc_nxt) == CRC_RESIDUE);
        end else if (beat_i.valid && beat_i.first) begin
            fcs_ok_o <= 1'b0;
        end
    end

endmodule

//--- design/rx_frame_ctrl.sv
// frame controller: bytes 0..7 of every frame are taken as preamble + sfd, not checked
// beat_o is decoded from two registers, last needs one byte of lookahead
// carrier extension (ctl_rise low, ctl_fall high) is neither a frame nor a gap
`timescale 1ns/1ps

module rx_frame_ctrl (
    input  logic                      mac_rx_clk,
    input  logic                      rst_n_i,
    input  mac_rx_pkg::rgmii_rx_t     rgmii_rx_i,
    output mac_rx_pkg::rx_beat_t      beat_o,
    output mac_rx_pkg::link_status_t  link_status_o
);
    import mac_rx_pkg::*;

    // ------------------------------------------------------------------------
    // signals
    // ------------------------------------------------------------------------
    rgmii_rx_t    in_q;             // input register
    frame_cnt_t   cnt_q;            // index of the byte now in in_q
    logic         in_dv;
    logic         in_er;
    logic         in_gap;
    logic         in_payload;       // byte in in_q is past the sfd

    // lookahead stage, one byte behind in_q
    byte_t        la_data_q;
    logic         la_valid_q;
    logic         la_first_q;
    logic         la_err_q;

    link_status_t status_q;

    // ------------------------------------------------------------------------
    // input register
    // ------------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_q <= '0;             // idle gap
        end else begin
            in_q <= rgmii_rx_i;
        end
    end

    assign in_dv  = in_q.ctl_rise;
    assign in_er  = in_q.ctl_rise & ~in_q.ctl_fall;    // dv=1, er=1
    assign in_gap = ~in_q.ctl_rise & ~in_q.ctl_fall;   // dv=0, er=0

    // ------------------------------------------------------------------------
    // byte counter, cleared whenever dv is low
    // ------------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (!in_dv) begin
            cnt_q <= '0;
        end else if (cnt_q != '1) begin
            cnt_q <= cnt_q + 1'b1;  // saturates on very long frames
        end
    end

    assign in_payload = in_dv && (cnt_q >= frame_cnt_t'(PREAMBLE_LEN));

    // ------------------------------------------------------------------------
    // lookahead stage
    // ------------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            la_valid_q <= 1'b0;
            la_first_q <= 1'b0;
            la_err_q   <= 1'b0;
        end else begin
            la_valid_q <= in_payload;
            la_first_q <= in_dv && (cnt_q == frame_cnt_t'(PREAMBLE_LEN));
            la_err_q   <= in_er;
        end
    end

    always_ff @(posedge mac_rx_clk) begin
        la_data_q <= in_q.data;
    end

    // in_q already holds the following byte, so dv low there marks last
    always_comb begin
        beat_o.data  = la_data_q;
        beat_o.valid = la_valid_q;
        beat_o.first = la_first_q;
        beat_o.last  = la_valid_q & ~in_dv;
        beat_o.err   = la_valid_q & la_err_q;
    end

    // ------------------------------------------------------------------------
    // in-band status: low nibble of rxd while the line is idle
    //   bit 0 link, bits 2:1 speed, bit 3 duplex
    // ------------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            status_q <= '0;
        end else if (in_gap) begin
            status_q <= '{link_up:     in_q.data[0],
                          speed:       link_speed_e'(in_q.data[2:1]),
                          full_duplex: in_q.data[3]};
        end
    end

    assign link_status_o = status_q;

endmodule

//--- design/rx_stream_out.sv
// output delay line, OUT_PIPE_DEPTH stages (1..16), several frames may be in flight
// per-frame verdicts ride along with the last beat and leave with eof
`timescale 1ns/1ps

module rx_stream_out #(
    parameter int OUT_PIPE_DEPTH = 5
) (
    input  logic                        mac_rx_clk,
    input  logic                        rst_n_i,
    input  mac_rx_pkg::rx_beat_t        beat_i,
    input  logic                        fcs_ok_i,   // valid 1 edge after last beat
    output mac_rx_pkg::mac_rx_stream_t  mac_rx_o,
    output logic                        fr_good_o,
    output logic                        fr_err_o
);
    import mac_rx_pkg::*;

    localparam int LAST = OUT_PIPE_DEPTH - 1;

    // control bits of one stage
    typedef struct packed {
        logic valid;
        logic sof;
        logic eof;
        logic err;          // sticky frame error, only set with eof
        logic good;         // fcs verdict, joins from stage 1 on
    } pipe_ctl_t;

    byte_t     data_q [OUT_PIPE_DEPTH];
    pipe_ctl_t ctl_q  [OUT_PIPE_DEPTH];
    logic      err_acc_q;   // any er so far in the current frame
    logic      frame_err;

    // ------------------------------------------------------------------------
    // sticky error at the input end
    // ------------------------------------------------------------------------
    assign frame_err = beat_i.err | (err_acc_q & ~beat_i.first);

    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_acc_q <= 1'b0;
        end else if (beat_i.valid) begin
            err_acc_q <= frame_err & ~beat_i.last;  // cleared after each frame
        end
    end

    // ------------------------------------------------------------------------
    // delay line
    // ------------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        data_q[0] <= beat_i.data;
        for (int i = 1; i < OUT_PIPE_DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < OUT_PIPE_DEPTH; i++) begin
                ctl_q[i] <= '0;
            end
        end else begin
            ctl_q[0] <= '{valid: beat_i.valid,
                          sof:   beat_i.valid & beat_i.first,
                          eof:   beat_i.valid & beat_i.last,
                          err:   beat_i.valid & beat_i.last & frame_err,
                          good:  1'b0};
            for (int i = 1; i < OUT_PIPE_DEPTH; i++) begin
                ctl_q[i] <= ctl_q[i-1];
                if (i == 1) begin
                    ctl_q[i].good <= fcs_ok_i & ctl_q[0].eof;   // crc settles here
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------
    always_comb begin
        mac_rx_o.data  = data_q[LAST];
        mac_rx_o.valid = ctl_q[LAST].valid;
        mac_rx_o.sof   = ctl_q[LAST].sof;
        mac_rx_o.eof   = ctl_q[LAST].eof;
    end

    // single stage: the verdict is still on fcs_ok_i when eof leaves
    assign fr_good_o = (OUT_PIPE_DEPTH == 1) ? (ctl_q[LAST].eof & fcs_ok_i)
                                             : ctl_q[LAST].good;
    assign fr_err_o  = ctl_q[LAST].err;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the receive MAC testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_mac_rx \
    -f vlog.f \
    -o sim_tb_mac_rx

./obj_dir/sim_tb_mac_rx +verilator+error+limit+100 | tee "$LOG"

if grep -q "^Finished with no errors$" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- verification/mac_rx_chk.sv
// protocol checks on the receive stream, bound into mac_rx_top
// all checks are off while rst_n_i is low, fail_cnt sums the failures seen
`timescale 1ns/1ps

module mac_rx_chk (
    input  logic                        mac_rx_clk,
    input  logic                        rst_n_i,
    input  mac_rx_pkg::mac_rx_stream_t  mac_rx_i,
    input  logic                        fr_good_i,
    input  logic                        fr_err_i
);
    logic        in_frame_q;            // between sof and eof
    int unsigned strobe_fails  = 0;
    int unsigned sof_fails     = 0;
    int unsigned verdict_fails = 0;
    int unsigned fail_cnt;              // read by the testbench

    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_frame_q <= 1'b0;
        end else if (mac_rx_i.valid && mac_rx_i.eof) begin
            in_frame_q <= 1'b0;         // single-beat frame ends here too
        end else if (mac_rx_i.valid && mac_rx_i.sof) begin
            in_frame_q <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // stream framing
    // ------------------------------------------------------------------------
    strobe_needs_valid: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        (mac_rx_i.sof || mac_rx_i.eof) |-> mac_rx_i.valid)
        else begin
            $error("sof or eof seen without valid");
            strobe_fails++;
        end

    no_nested_sof: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        (mac_rx_i.valid && mac_rx_i.sof) |-> !in_frame_q)
        else begin
            $error("second sof before the eof of the open frame");
            sof_fails++;
        end

    // verdicts only travel with eof
    verdict_with_eof: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        (fr_good_i || fr_err_i) |-> (mac_rx_i.valid && mac_rx_i.eof))
        else begin
            $error("fr_good_o or fr_err_o high away from eof");
            verdict_fails++;
        end

    assign fail_cnt = strobe_fails + sof_fails + verdict_fails;

endmodule

//--- verification/tb_mac_rx.sv
// testbench for mac_rx_top with frames built here along with their own FCS
// outputs are sampled on the falling edge and inputs driven 1 ns after the rising edge
`timescale 1ns/1ps

module tb_mac_rx;
    import mac_rx_pkg::*;

    localparam int WAIT_LIMIT = 400;    // cycles allowed for a batch to drain

    // expected output beat
    typedef struct packed {
        byte_t data;
        logic  sof;
        logic  eof;
        logic  good;                    // only looked at with eof
        logic  err;
    } exp_beat_t;

    logic           mac_rx_clk;
    logic           rst_n_i;
    rgmii_rx_t      rgmii_rx_i;
    mac_rx_stream_t mac_rx_o;
    logic           fr_good_o;
    logic           fr_err_o;
    link_status_t   link_status_o;

    exp_beat_t exp_q[$];
    exp_beat_t head;
    byte_t     gap_byte    = 8'h00;     // idle value that carries the status nibble
    int        frames_sent = 0;
    int        frames_done = 0;
    int        beats_seen  = 0;
    int        tests_done  = 0;
    int        err_cnt     = 0;
    logic      timed_out   = 1'b0;

    mac_rx_top #(.OUT_PIPE_DEPTH(5)) UUT (
        .mac_rx_clk    (mac_rx_clk),
        .rst_n_i       (rst_n_i),
        .rgmii_rx_i    (rgmii_rx_i),
        .mac_rx_o      (mac_rx_o),
        .fr_good_o     (fr_good_o),
        .fr_err_o      (fr_err_o),
        .link_status_o (link_status_o)
    );

    bind mac_rx_top mac_rx_chk u_chk (
        .mac_rx_clk (mac_rx_clk),
        .rst_n_i    (rst_n_i),
        .mac_rx_i   (mac_rx_o),
        .fr_good_i  (fr_good_o),
        .fr_err_i   (fr_err_o)
    );

    always #50 mac_rx_clk = ~mac_rx_clk;   // 100 ns period

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    // 802.3 crc in an msb-first register fed lsb first
    function automatic crc_t crc_step(input crc_t crc, input byte_t d);
        crc_t c;
        logic fb;
        c = crc;
        for (int b = 0; b < 8; b++) begin
            fb = c[31] ^ d[b];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ 32'h04C11DB7;
            end
        end
        return c;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (exp === act) else begin
            $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic drive_byte(input byte_t d, input logic dv, input logic er);
        @(posedge mac_rx_clk);
        #1;
        rgmii_rx_i = '{data: d, ctl_rise: dv, ctl_fall: dv ^ er};
    endtask

    // preamble and sfd, then payload and fcs, then the gap
    // err_pos < 0 means no er
    task automatic send_frame(input int len, input logic bad_fcs, input int err_pos,
                              input int gap);
        byte_t     pl[$];
        crc_t      crc;
        crc_t      fcs;
        exp_beat_t e;
        crc = '1;
        for (int i = 0; i < len; i++) begin
            pl.push_back(byte_t'($urandom()));
            crc = crc_step(crc, pl[i]);
        end
        for (int b = 0; b < 32; b++) begin
            fcs[b] = ~crc[31-b];            // reflect and invert
        end
        if (bad_fcs) begin
            fcs = fcs ^ (crc_t'(1) << $urandom_range(31, 0));
        end
        for (int k = 0; k < 4; k++) begin
            pl.push_back(fcs[8*k +: 8]);    // low byte first
        end
        for (int i = 0; i < pl.size(); i++) begin
            e = '{data: pl[i], sof: (i == 0), eof: (i == pl.size() - 1),
                  good: !bad_fcs, err: (err_pos >= 0)};
            exp_q.push_back(e);
        end
        repeat (7) drive_byte(8'h55, 1'b1, 1'b0);
        drive_byte(8'hD5, 1'b1, 1'b0);      // sfd
        for (int i = 0; i < pl.size(); i++) begin
            drive_byte(pl[i], 1'b1, (i == err_pos));
        end
        repeat (gap) drive_byte(gap_byte, 1'b0, 1'b0);
        frames_sent++;
    endtask

    task automatic wait_frames(input string name);
        int cycles;
        cycles = 0;
        while (frames_done < frames_sent && cycles < WAIT_LIMIT) begin
            @(posedge mac_rx_clk);
            cycles++;
        end
        if (frames_done < frames_sent) begin
            $display("timeout in %s: frame %0d of %0d never ended", name,
                     frames_done + 1, frames_sent);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name);
        if (!timed_out) begin
            tests_done++;
            $display("test %s done, %0d errors so far", name,
                     err_cnt + int'(UUT.u_chk.fail_cnt));
        end
    endtask

    // ------------------------------------------------------------------------
    // output monitor pops one expected beat per valid
    // ------------------------------------------------------------------------
    always @(negedge mac_rx_clk) begin
        if (rst_n_i && mac_rx_o.valid) begin
            beats_seen++;
            assert (exp_q.size() != 0) else begin
                $display("%0t: output beat came out with no frame in flight", $time);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                check_val("mac_rx_o.data", 32'(head.data), 32'(mac_rx_o.data));
                check_val("mac_rx_o.sof", 32'(head.sof), 32'(mac_rx_o.sof));
                check_val("mac_rx_o.eof", 32'(head.eof), 32'(mac_rx_o.eof));
                if (head.eof) begin
                    check_val("fr_good_o", 32'(head.good), 32'(fr_good_o));
                    check_val("fr_err_o", 32'(head.err), 32'(fr_err_o));
                    frames_done++;
                end
            end
        end else if (rst_n_i && exp_q.size() != 0 && !exp_q[0].sof) begin
            // inside a frame the stream has no holes
            check_val("mac_rx_o.valid", 32'h1, 32'(mac_rx_o.valid));
        end
    end

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic check_reset_state();
        @(negedge mac_rx_clk);
        check_val("mac_rx_o.valid", 32'h0, 32'(mac_rx_o.valid));
        check_val("mac_rx_o.sof", 32'h0, 32'(mac_rx_o.sof));
        check_val("mac_rx_o.eof", 32'h0, 32'(mac_rx_o.eof));
        check_val("fr_good_o", 32'h0, 32'(fr_good_o));
        check_val("fr_err_o", 32'h0, 32'(fr_err_o));
        check_val("link_status_o", 32'h0, 32'(link_status_o));
        report_test("reset_state");
    endtask

    // kind 0 good, 1 flipped fcs bit, 2 er on a mid-payload byte
    task automatic test_frames(input string name, input int kind, input int count);
        int len;
        for (int i = 0; i < count; i++) begin
            len = int'($urandom_range(60, 10));
            send_frame(len, (kind == 1), (kind == 2) ? len / 2 : -1,
                       int'($urandom_range(12, 1)));
        end
        wait_frames(name);
        report_test(name);
    endtask

    task automatic test_link_status();
        logic [3:0]   nib;
        link_status_t exp;
        for (int s = 0; s < 3; s++) begin
            for (int ld = 0; ld < 4; ld++) begin
                nib      = {ld[1], s[1:0], ld[0]};      // duplex, speed, link
                gap_byte = {4'($urandom()), nib};       // high nibble ignored
                repeat (3) drive_byte(gap_byte, 1'b0, 1'b0);
                @(negedge mac_rx_clk);
                exp = '{link_up: ld[0], speed: link_speed_e'(s[1:0]),
                        full_duplex: ld[1]};
                check_val("link_status_o", 32'(exp), 32'(link_status_o));
            end
        end
        report_test("link_status");
    endtask

    task automatic test_runt_b2b();
        repeat (6) drive_byte(8'h55, 1'b1, 1'b0);      // ends inside the preamble
        repeat (3) drive_byte(gap_byte, 1'b0, 1'b0);
        for (int i = 0; i < 5; i++) begin
            send_frame(int'($urandom_range(60, 10)), 1'b0, -1, 1);
        end
        wait_frames("runt_b2b");
        report_test("runt_b2b");
    endtask

    task automatic finish_report();
        int total;
        assert (timed_out || exp_q.size() == 0) else begin
            $display("%0d expected beats never came out", exp_q.size());
            err_cnt++;
        end
        total = err_cnt + int'(UUT.u_chk.fail_cnt);
        $display("summary: %0d tests, %0d frames, %0d beats, %0d errors",
                 tests_done, frames_done, beats_seen, total);
        if (total == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        mac_rx_clk = 1'b0;
        rst_n_i    = 1'b0;
        rgmii_rx_i = '0;                    // idle gap
        void'($urandom(33348));
        repeat (5) @(posedge mac_rx_clk);
        #1;
        rst_n_i = 1'b1;
        check_reset_state();
        test_frames("good_frames", 0, 20);
        if (!timed_out) test_frames("bad_fcs", 1, 4);
        if (!timed_out) test_frames("rx_error", 2, 4);
        if (!timed_out) test_link_status();
        if (!timed_out) test_runt_b2b();
        finish_report();
    end

endmodule

//--- vlog.f
design/mac_rx_pkg.sv
design/rx_frame_ctrl.sv
design/rx_crc32_check.sv
design/rx_stream_out.sv
design/mac_rx_top.sv
verification/mac_rx_chk.sv
verification/tb_mac_rx.sv
